// File: mmu_pkg.sv
package mmu_pkg;

    // access kind seen by the translation unit
    typedef enum logic [1:0] {
        MEM_FETCH = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_t;

    // current mode register
    typedef struct packed {
        logic [1:0] plv;   // privilege level
        logic       da;    // direct address mode
        logic       pg;    // paging enabled
        logic [1:0] datf;  // fetch mat in direct mode
        logic [1:0] datm;  // data mat in direct mode
    } crmd_t;

    // one direct-mapped window
    typedef struct packed {
        logic       plv0;  // usable at level 0
        logic       plv3;  // usable at level 3
        logic [1:0] mat;
        logic [2:0] pseg;  // physical segment
        logic [2:0] vseg;  // virtual segment
    } dmw_t;

    // csr fields the unit needs
    typedef struct packed {
        crmd_t       crmd;
        logic [9:0]  asid;
        dmw_t        dmw0;
        dmw_t        dmw1;
    } csr_t;

    typedef struct packed {
        logic        e;          // entry exists
        logic        g;          // global, ignores asid
        logic [9:0]  asid;
        logic        huge_page;  // 2 MB pair instead of 4 KB pair
        logic [18:0] vppn;       // va[31:13]
    } tlb_key_t;

    typedef struct packed {
        logic        v;    // valid
        logic        d;    // dirty, page writable
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic [19:0] ppn;
    } tlb_value_t;

    // value[0] even page, value[1] odd page
    typedef struct packed {
        tlb_key_t        key;
        tlb_value_t [1:0] value;
    } tlb_entry_t;

    typedef struct packed {
        logic [31:0] pa;
        logic [1:0]  mat;
        logic        valid;
    } trans_result_t;

    typedef struct packed {
        logic [5:0] ecode;
    } tlb_exception_t;

    // exception codes, only meaningful while the result is not valid
    localparam logic [5:0] ECODE_NONE = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;  // load on invalid page
    localparam logic [5:0] ECODE_PIS  = 6'h02;  // store on invalid page
    localparam logic [5:0] ECODE_PIF  = 6'h03;  // fetch on invalid page
    localparam logic [5:0] ECODE_PME  = 6'h04;  // store to clean page
    localparam logic [5:0] ECODE_PPI  = 6'h07;  // privilege too low
    localparam logic [5:0] ECODE_TLBR = 6'h3F;  // tlb refill

endpackage

// File: tlb_array.sv
`timescale 1ns/1ps

module tlb_array import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16,
    localparam int unsigned IDX_W = $clog2(TLB_ENTRY_NUM)
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                we_i,
    input  logic [IDX_W-1:0]                    windex_i,
    input  tlb_entry_t                          wentry_i,
    input  logic [IDX_W-1:0]                    rindex_i,
    output tlb_key_t   [TLB_ENTRY_NUM-1:0]      keys_o,
    output tlb_value_t [TLB_ENTRY_NUM-1:0][1:0] values_o,
    output tlb_entry_t                          rentry_o
);

    logic       [TLB_ENTRY_NUM-1:0]      e_q;      // exist bits, the only reset state
    tlb_key_t   [TLB_ENTRY_NUM-1:0]      key_q;
    tlb_value_t [TLB_ENTRY_NUM-1:0][1:0] value_q;
    tlb_entry_t                          rentry_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            e_q <= '0;
        end else if (we_i) begin
            e_q[windex_i] <= wentry_i.key.e;
        end
    end

    // payload of the entries
    always_ff @(posedge clk) begin
        if (we_i) begin
            key_q[windex_i]   <= wentry_i.key;
            value_q[windex_i] <= wentry_i.value;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            keys_o[i]   = key_q[i];
            keys_o[i].e = e_q[i];  // stored e replaced by the reset copy
        end
    end

    assign values_o = value_q;

    // maintenance read, one cycle after the index
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rentry_q <= '0;
        end else begin
            rentry_q.key   <= keys_o[rindex_i];
            rentry_q.value <= values_o[rindex_i];
        end
    end

    assign rentry_o = rentry_q;

    a_windex_in_range : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        we_i |-> (windex_i < TLB_ENTRY_NUM)
    ) else $error("tlb write index %0d out of range", windex_i);

endmodule

// File: tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16
) (
    input  logic [31:0]                         va_i,
    input  logic [9:0]                          asid_i,
    input  tlb_key_t   [TLB_ENTRY_NUM-1:0]      keys_i,
    input  tlb_value_t [TLB_ENTRY_NUM-1:0][1:0] values_i,
    output logic                                hit_o,
    output tlb_value_t                          hit_value_o,
    output logic                                hit_huge_o
);

    logic [TLB_ENTRY_NUM-1:0] match;

    // huge pages compare only the top ten vppn bits
    function automatic logic page_match(
        input logic [31:0] va,
        input logic        huge,
        input logic [18:0] vppn
    );
        if (huge) begin
            return va[31:22] == vppn[18:9];
        end
        return va[31:13] == vppn;
    endfunction

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            match[i] = keys_i[i].e
                    && (keys_i[i].g || (keys_i[i].asid == asid_i))
                    && page_match(va_i, keys_i[i].huge_page, keys_i[i].vppn);
        end
    end

    assign hit_o = |match;

    // one-hot match, so an or over the hits selects the entry
    always_comb begin
        logic odd;
        hit_value_o = '0;
        hit_huge_o  = 1'b0;
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            odd = keys_i[i].huge_page ? va_i[21] : va_i[12];  // pair select
            if (match[i]) begin
                hit_value_o = hit_value_o | values_i[i][odd];
                hit_huge_o  = hit_huge_o | keys_i[i].huge_page;
            end
        end
    end

    a_match_onehot : assert final ($onehot0(match))
        else $error("multiple tlb entries match va %h", va_i);

endmodule

// File: dmw_match.sv
`timescale 1ns/1ps

module dmw_match import mmu_pkg::*; (
    input  logic [31:0] va_i,
    input  crmd_t       crmd_i,
    input  dmw_t        dmw0_i,
    input  dmw_t        dmw1_i,
    output logic        dmw_hit_o,
    output dmw_t        dmw_sel_o
);

    logic at_plv0;
    logic at_plv3;
    logic plv_ok0;
    logic plv_ok1;
    logic hit0;
    logic hit1;

    assign at_plv0 = (crmd_i.plv == 2'd0);
    assign at_plv3 = (crmd_i.plv == 2'd3);

    // levels 1 and 2 never use a window
    assign plv_ok0 = (at_plv0 && dmw0_i.plv0) || (at_plv3 && dmw0_i.plv3);
    assign plv_ok1 = (at_plv0 && dmw1_i.plv0) || (at_plv3 && dmw1_i.plv3);

    assign hit0 = plv_ok0 && (dmw0_i.vseg == va_i[31:29]);
    assign hit1 = plv_ok1 && (dmw1_i.vseg == va_i[31:29]);

    assign dmw_hit_o = hit0 || hit1;

    // window 0 wins when both hit
    always_comb begin
        if (hit0) begin
            dmw_sel_o = dmw0_i;
        end else if (hit1) begin
            dmw_sel_o = dmw1_i;
        end else begin
            dmw_sel_o = '0;
        end
    end

endmodule

// File: trans_check.sv
`timescale 1ns/1ps

module trans_check import mmu_pkg::*; (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           flush_i,
    input  logic [31:0]    va_i,
    input  mem_type_t      mem_type_i,
    input  crmd_t          crmd_i,
    input  logic           dmw_hit_i,
    input  dmw_t           dmw_sel_i,
    input  logic           tlb_hit_i,
    input  tlb_value_t     tlb_value_i,
    input  logic           huge_i,
    output trans_result_t  trans_result_o,
    output tlb_exception_t tlb_exception_o
);

    trans_result_t  result_d;
    tlb_exception_t exc_d;
    trans_result_t  result_q;
    tlb_exception_t exc_q;
    logic [31:0]    tlb_pa;

    // 2 MB page keeps va[20:0], 4 KB page keeps va[11:0]
    assign tlb_pa = huge_i ? {tlb_value_i.ppn[19:9], va_i[20:0]}
                           : {tlb_value_i.ppn, va_i[11:0]};

    always_comb begin
        result_d  = '0;
        exc_d     = '0;
        if (crmd_i.da) begin
            result_d.pa    = va_i;
            result_d.mat   = (mem_type_i == MEM_FETCH) ? crmd_i.datf : crmd_i.datm;
            result_d.valid = 1'b1;
        end else if (dmw_hit_i) begin
            result_d.pa    = {dmw_sel_i.pseg, va_i[28:0]};
            result_d.mat   = dmw_sel_i.mat;
            result_d.valid = 1'b1;
        end else begin
            result_d.pa  = tlb_pa;
            result_d.mat = tlb_value_i.mat;
            if (!tlb_hit_i) begin
                exc_d.ecode = ECODE_TLBR;
            end else if (!tlb_value_i.v) begin
                case (mem_type_i)
                    MEM_FETCH: exc_d.ecode = ECODE_PIF;
                    MEM_LOAD:  exc_d.ecode = ECODE_PIL;
                    default:   exc_d.ecode = ECODE_PIS;
                endcase
            end else if (crmd_i.plv > tlb_value_i.plv) begin
                exc_d.ecode = ECODE_PPI;
            end else if ((mem_type_i == MEM_STORE) && !tlb_value_i.d) begin
                exc_d.ecode = ECODE_PME;
            end
            // valid only when the page passes every access check
            result_d.valid = tlb_hit_i && tlb_value_i.v
                          && (crmd_i.plv <= tlb_value_i.plv)
                          && !((mem_type_i == MEM_STORE) && !tlb_value_i.d);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q <= '0;
            exc_q    <= '0;
        end else if (flush_i) begin
            result_q <= '0;
            exc_q    <= '0;
        end else begin
            result_q <= result_d;
            exc_q    <= exc_d;
        end
    end

    assign trans_result_o  = result_q;
    assign tlb_exception_o = exc_q;

    a_ecode_only_invalid : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (tlb_exception_o.ecode != ECODE_NONE) |-> !trans_result_o.valid
    ) else $error("ecode %h reported with a valid translation", tlb_exception_o.ecode);

endmodule

// File: mmu_top.sv
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16,
    localparam int unsigned IDX_W = $clog2(TLB_ENTRY_NUM)
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             flush_i,
    input  logic [31:0]      va_i,
    input  mem_type_t        mem_type_i,
    input  csr_t             csr_i,
    input  logic             tlb_we_i,
    input  logic [IDX_W-1:0] tlb_windex_i,
    input  logic [IDX_W-1:0] tlb_rindex_i,
    input  tlb_entry_t       tlb_wentry_i,
    output trans_result_t    trans_result_o,
    output tlb_exception_t   tlb_exception_o,
    output tlb_entry_t       tlb_entry_o
);

    tlb_key_t   [TLB_ENTRY_NUM-1:0]      keys;
    tlb_value_t [TLB_ENTRY_NUM-1:0][1:0] values;
    logic                                tlb_hit;
    tlb_value_t                          tlb_hit_value;
    logic                                tlb_hit_huge;
    logic                                dmw_hit;
    dmw_t                                dmw_sel;

    tlb_array #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) i_tlb_array (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (tlb_we_i),
        .windex_i (tlb_windex_i),
        .wentry_i (tlb_wentry_i),
        .rindex_i (tlb_rindex_i),
        .keys_o   (keys),
        .values_o (values),
        .rentry_o (tlb_entry_o)
    );

    tlb_lookup #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) i_tlb_lookup (
        .va_i        (va_i),
        .asid_i      (csr_i.asid),
        .keys_i      (keys),
        .values_i    (values),
        .hit_o       (tlb_hit),
        .hit_value_o (tlb_hit_value),
        .hit_huge_o  (tlb_hit_huge)
    );

    dmw_match i_dmw_match (
        .va_i      (va_i),
        .crmd_i    (csr_i.crmd),
        .dmw0_i    (csr_i.dmw0),
        .dmw1_i    (csr_i.dmw1),
        .dmw_hit_o (dmw_hit),
        .dmw_sel_o (dmw_sel)
    );

    trans_check i_trans_check (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .va_i            (va_i),
        .mem_type_i      (mem_type_i),
        .crmd_i          (csr_i.crmd),
        .dmw_hit_i       (dmw_hit),
        .dmw_sel_i       (dmw_sel),
        .tlb_hit_i       (tlb_hit),
        .tlb_value_i     (tlb_hit_value),
        .huge_i          (tlb_hit_huge),
        .trans_result_o  (trans_result_o),
        .tlb_exception_o (tlb_exception_o)
    );

endmodule

// File: tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu import mmu_pkg::*; ();

    localparam int unsigned TLB_ENTRY_NUM = 16;
    localparam int unsigned IDX_W         = $clog2(TLB_ENTRY_NUM);
    localparam int          MAX_CYCLES    = 500;

    typedef struct {
        logic [31:0] va;
        mem_type_t   mtype;
        csr_t        csr;
        logic        flush;
        logic [31:0] pa;     // expected values from here on
        logic [1:0]  mat;
        logic        valid;
        logic [5:0]  ecode;
    } lookup_row_t;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             flush;
    logic [31:0]      va;
    mem_type_t        mem_type;
    csr_t             csr;
    logic             tlb_we;
    logic [IDX_W-1:0] tlb_windex;
    logic [IDX_W-1:0] tlb_rindex;
    tlb_entry_t       tlb_wentry;
    trans_result_t    trans_result;
    tlb_exception_t   tlb_exception;
    tlb_entry_t       tlb_entry;

    logic [IDX_W-1:0] preload_idx[$];
    tlb_entry_t       preload_entry[$];
    lookup_row_t      rows[$];

    always #2 clk = ~clk;

    mmu_top #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) i_mmu_top (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .flush_i         (flush),
        .va_i            (va),
        .mem_type_i      (mem_type),
        .csr_i           (csr),
        .tlb_we_i        (tlb_we),
        .tlb_windex_i    (tlb_windex),
        .tlb_rindex_i    (tlb_rindex),
        .tlb_wentry_i    (tlb_wentry),
        .trans_result_o  (trans_result),
        .tlb_exception_o (tlb_exception),
        .tlb_entry_o     (tlb_entry)
    );

    // window 0 maps 0x8xxxxxxx at level 0, window 1 maps 0xaxxxxxxx at level 3
    function automatic csr_t make_csr(input logic [1:0] plv, input logic da,
                                      input logic [9:0] asid);
        csr_t c;
        c            = '0;
        c.crmd.plv   = plv;
        c.crmd.da    = da;
        c.crmd.pg    = !da;
        c.crmd.datf  = 2'd2;
        c.crmd.datm  = 2'd1;
        c.asid       = asid;
        c.dmw0.plv0  = 1'b1;
        c.dmw0.mat   = 2'd1;
        c.dmw0.pseg  = 3'd0;
        c.dmw0.vseg  = 3'd4;
        c.dmw1.plv3  = 1'b1;
        c.dmw1.mat   = 2'd2;
        c.dmw1.pseg  = 3'd1;
        c.dmw1.vseg  = 3'd5;
        return c;
    endfunction

    function automatic tlb_value_t make_value(input logic v, input logic d,
                                              input logic [1:0] plv, input logic [1:0] mat,
                                              input logic [19:0] ppn);
        tlb_value_t x;
        x.v   = v;
        x.d   = d;
        x.plv = plv;
        x.mat = mat;
        x.ppn = ppn;
        return x;
    endfunction

    function automatic tlb_entry_t make_entry(input logic g, input logic [9:0] asid,
                                              input logic huge, input logic [18:0] vppn,
                                              input tlb_value_t even, input tlb_value_t odd);
        tlb_entry_t t;
        t.key.e         = 1'b1;
        t.key.g         = g;
        t.key.asid      = asid;
        t.key.huge_page = huge;
        t.key.vppn      = vppn;
        t.value[0]      = even;
        t.value[1]      = odd;
        return t;
    endfunction

    task automatic add_row(input logic [31:0] row_va, input mem_type_t mtype,
                           input csr_t row_csr, input logic row_flush, input logic [31:0] pa,
                           input logic [1:0] mat, input logic valid, input logic [5:0] ecode);
        lookup_row_t r;
        r.va    = row_va;
        r.mtype = mtype;
        r.csr   = row_csr;
        r.flush = row_flush;
        r.pa    = pa;
        r.mat   = mat;
        r.valid = valid;
        r.ecode = ecode;
        rows.push_back(r);
    endtask

    task automatic build_tables();
        csr_t da;
        csr_t p0;
        csr_t p3;
        da = make_csr(2'd0, 1'b1, 10'h010);
        p0 = make_csr(2'd0, 1'b0, 10'h010);
        p3 = make_csr(2'd3, 1'b0, 10'h010);
        // small non-global pair at 0x00400000
        preload_idx.push_back(4'd0);
        preload_entry.push_back(make_entry(1'b0, 10'h010, 1'b0, 19'h00200,
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h12345),
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h23456)));
        // huge global pair at 0x04000000
        preload_idx.push_back(4'd1);
        preload_entry.push_back(make_entry(1'b1, 10'h000, 1'b1, 19'h02000,
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h00A00),
            make_value(1'b1, 1'b1, 2'd3, 2'd0, 20'h00C00)));
        // even page invalid, odd page clean
        preload_idx.push_back(4'd2);
        preload_entry.push_back(make_entry(1'b1, 10'h000, 1'b0, 19'h00280,
            make_value(1'b0, 1'b1, 2'd3, 2'd1, 20'h00000),
            make_value(1'b1, 1'b0, 2'd3, 2'd1, 20'h33333)));
        preload_idx.push_back(4'd3);
        preload_entry.push_back(make_entry(1'b0, 10'h020, 1'b0, 19'h00300,
            make_value(1'b1, 1'b1, 2'd0, 2'd1, 20'h44444),   // kernel only
            make_value(1'b1, 1'b1, 2'd3, 2'd2, 20'h55555)));
        preload_idx.push_back(4'd4);
        preload_entry.push_back(make_entry(1'b0, 10'h010, 1'b0, 19'h00380,
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h66666),
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h66667)));
        preload_idx.push_back(4'd5);
        preload_entry.push_back(make_entry(1'b0, 10'h020, 1'b1, 19'h04000,
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h01000),
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h01200)));
        preload_idx.push_back(4'd15);
        preload_entry.push_back(make_entry(1'b1, 10'h000, 1'b0, 19'h00500,
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h77777),
            make_value(1'b1, 1'b1, 2'd3, 2'd1, 20'h78888)));

        add_row(32'h1234_5678, MEM_FETCH, da, 1'b0, 32'h1234_5678, 2'd2, 1'b1, ECODE_NONE);
        add_row(32'h8765_4320, MEM_LOAD,  da, 1'b0, 32'h8765_4320, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'h8123_4560, MEM_LOAD,  p0, 1'b0, 32'h0123_4560, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'hA123_4560, MEM_LOAD,  p3, 1'b0, 32'h2123_4560, 2'd2, 1'b1, ECODE_NONE);
        add_row(32'h8123_4560, MEM_LOAD,  p3, 1'b0, 32'h0, 2'd0, 1'b0, ECODE_TLBR);
        add_row(32'h0040_0ABC, MEM_LOAD,  p0, 1'b0, 32'h1234_5ABC, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'h0040_1DEF, MEM_LOAD,  p0, 1'b0, 32'h2345_6DEF, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'h0040_0ABC, MEM_LOAD, make_csr(2'd0, 1'b0, 10'h011), 1'b0,
                32'h0, 2'd0, 1'b0, ECODE_TLBR);                  // wrong asid
        add_row(32'h0412_3456, MEM_LOAD, make_csr(2'd0, 1'b0, 10'h3FF), 1'b0,
                32'h00B2_3456, 2'd1, 1'b1, ECODE_NONE);          // global, any asid
        add_row(32'h0432_1000, MEM_LOAD,  p0, 1'b0, 32'h00D2_1000, 2'd0, 1'b1, ECODE_NONE);
        add_row(32'h0050_0100, MEM_FETCH, p0, 1'b0, 32'h0, 2'd0, 1'b0, ECODE_PIF);
        add_row(32'h0050_0100, MEM_LOAD,  p0, 1'b0, 32'h0, 2'd0, 1'b0, ECODE_PIL);
        add_row(32'h0050_0100, MEM_STORE, p0, 1'b0, 32'h0, 2'd0, 1'b0, ECODE_PIS);
        add_row(32'h0050_1100, MEM_STORE, p0, 1'b0, 32'h0, 2'd0, 1'b0, ECODE_PME);
        add_row(32'h0050_1100, MEM_LOAD,  p0, 1'b0, 32'h3333_3100, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'h0060_0040, MEM_LOAD, make_csr(2'd3, 1'b0, 10'h020), 1'b0,
                32'h0, 2'd0, 1'b0, ECODE_PPI);
        add_row(32'h0060_0040, MEM_LOAD, make_csr(2'd0, 1'b0, 10'h020), 1'b0,
                32'h4444_4040, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'h0830_0008, MEM_STORE, make_csr(2'd3, 1'b0, 10'h020), 1'b0,
                32'h0130_0008, 2'd1, 1'b1, ECODE_NONE);
        add_row(32'h1234_5678, MEM_FETCH, da, 1'b1, 32'h0, 2'd0, 1'b0, ECODE_NONE);  // flush
        add_row(32'h00F0_0000, MEM_LOAD,  p0, 1'b0, 32'h0, 2'd0, 1'b0, ECODE_TLBR);
        add_row(32'h0070_0123, MEM_LOAD,  p0, 1'b0, 32'h6666_6123, 2'd1, 1'b1, ECODE_NONE);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_result(input int idx, input logic [31:0] pa, input logic [1:0] mat,
                                input logic valid, input logic [5:0] ecode,
                                input logic full);
        // pa and mat carry no meaning on an invalid translation
        if (valid || full) begin
            check_field($sformatf("trans_result_o.pa row %0d", idx), trans_result.pa, pa);
            check_field($sformatf("trans_result_o.mat row %0d", idx),
                        32'(trans_result.mat), 32'(mat));
        end
        check_field($sformatf("trans_result_o.valid row %0d", idx),
                    32'(trans_result.valid), 32'(valid));
        check_field($sformatf("tlb_exception_o.ecode row %0d", idx),
                    32'(tlb_exception.ecode), 32'(ecode));
    endtask

    task automatic check_entry(input tlb_entry_t exp);
        check_field("tlb_entry_o.key", tlb_entry.key, exp.key);
        check_field("tlb_entry_o.value[0]", 32'(tlb_entry.value[0]), 32'(exp.value[0]));
        check_field("tlb_entry_o.value[1]", 32'(tlb_entry.value[1]), 32'(exp.value[1]));
    endtask

    initial begin : watchdog
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        tlb_entry_t new_entry;
        arst_n     <= 1'b0;
        flush      <= 1'b0;
        va         <= '0;
        mem_type   <= MEM_FETCH;
        csr        <= '0;
        tlb_we     <= 1'b0;
        tlb_windex <= '0;
        tlb_rindex <= '0;
        tlb_wentry <= '0;
        build_tables();

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        @(negedge clk);
        check_result(-1, 32'h0, 2'd0, 1'b0, ECODE_NONE, 1'b1);
        check_entry('0);

        // preload, nothing translates while csr is all zero
        for (int i = 0; i < preload_idx.size(); i++) begin
            @(posedge clk);
            tlb_we     <= 1'b1;
            tlb_windex <= preload_idx[i];
            tlb_wentry <= preload_entry[i];
            @(negedge clk);
            check_field("trans_result_o.valid", 32'(trans_result.valid), 32'd0);
        end
        @(posedge clk);
        tlb_we <= 1'b0;

        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            va       <= rows[r].va;
            mem_type <= rows[r].mtype;
            csr      <= rows[r].csr;
            flush    <= rows[r].flush;
            @(posedge clk);   // result registered here
            @(negedge clk);
            check_result(r, rows[r].pa, rows[r].mat, rows[r].valid, rows[r].ecode,
                         rows[r].flush);
        end

        // maintenance read of the last index
        @(posedge clk);
        tlb_rindex <= 4'd15;
        @(posedge clk);
        @(negedge clk);
        check_entry(preload_entry[preload_entry.size() - 1]);

        // rewrite entry 4, then look it up and read it back
        new_entry = make_entry(1'b0, 10'h010, 1'b0, 19'h00380,
                               make_value(1'b1, 1'b1, 2'd3, 2'd2, 20'h0ABCD),
                               make_value(1'b1, 1'b1, 2'd3, 2'd2, 20'h0ABCE));
        @(posedge clk);
        tlb_we     <= 1'b1;
        tlb_windex <= 4'd4;
        tlb_wentry <= new_entry;
        tlb_rindex <= 4'd4;
        @(posedge clk);
        tlb_we   <= 1'b0;
        va       <= 32'h0070_0123;
        mem_type <= MEM_LOAD;
        csr      <= make_csr(2'd0, 1'b0, 10'h010);
        flush    <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_result(99, 32'h0ABC_D123, 2'd2, 1'b1, ECODE_NONE, 1'b0);
        check_entry(new_entry);

        $display("test passed");
        $finish;
    end

endmodule

// File: compile.f
mmu_pkg.sv
tlb_array.sv
tlb_lookup.sv
dmw_match.sv
trans_check.sv
mmu_top.sv
tb_mmu.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_mmu
FILELIST ?= compile.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
